// File: logic/cpu_types_pkg.sv
package cpu_types_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [4:0]  exccode_t;
    typedef logic [2:0]  hilo_cmd_t;

    // address error codes as written to cause.exccode
    localparam exccode_t EXC_ADEL = 5'd4;
    localparam exccode_t EXC_ADES = 5'd5;

    // hi/lo commands
    localparam hilo_cmd_t HILO_NONE = 3'd0;
    localparam hilo_cmd_t HILO_MFHI = 3'd1;
    localparam hilo_cmd_t HILO_MFLO = 3'd2;
    localparam hilo_cmd_t HILO_MTHI = 3'd3;
    localparam hilo_cmd_t HILO_MTLO = 3'd4;
    localparam hilo_cmd_t HILO_MULT = 3'd5; // product high half to hi, low half to lo

endpackage

// File: logic/dcache_request_stage.sv
module dcache_request_stage #(
    parameter int CACHE_INDEX_W  = 8,
    parameter int CACHE_OFFSET_W = 4
) (
    input  logic                                     clk,
    input  logic                                     reset,
    stage_if.request                                 up,
    output logic                                     dcache_valid,
    output logic                                     dcache_op,
    output logic                                     dcache_uncache,
    output logic [31-CACHE_INDEX_W-CACHE_OFFSET_W:0] dcache_tag,
    output logic [CACHE_INDEX_W-1:0]                 dcache_index,
    output logic [CACHE_OFFSET_W-1:0]                dcache_offset,
    output mem_op_pkg::acc_size_t                    dcache_size,
    output mem_op_pkg::wstrb_t                       dcache_wstrb,
    output cpu_types_pkg::word_t                     dcache_wdata,
    input  logic                                     dcache_addr_ok,
    output logic                                     out_valid,
    input  logic                                     out_allowin,
    output cpu_types_pkg::word_t                     out_pc,
    output cpu_types_pkg::reg_idx_t                  out_dest,
    output logic                                     out_load,
    output mem_op_pkg::ls_type_t                     out_ls_type,
    output mem_op_pkg::byte_off_t                    out_offset,
    output cpu_types_pkg::word_t                     out_result
);
    import cpu_types_pkg::*;
    import mem_op_pkg::*;

    localparam int TAG_W = 32 - CACHE_INDEX_W - CACHE_OFFSET_W;

    logic      valid_r;
    logic      accepted;
    word_t     pc_r;
    reg_idx_t  dest_r;
    ls_type_t  ls_type_r;
    logic      load_r;
    logic      store_r;
    word_t     addr_r;
    word_t     rs_value_r;
    word_t     rt_value_r;
    word_t     alu_result_r;
    hilo_cmd_t hilo_cmd_r;
    dword_t    mul_res_r;
    logic      mem_op;
    logic      ready_go;
    logic      leave;
    word_t     vaddr;
    word_t     paddr;
    word_t     hilo_value;

    assign mem_op   = load_r || store_r;
    assign ready_go = !mem_op || accepted || dcache_addr_ok;
    assign leave    = out_valid && out_allowin;

    assign out_valid  = valid_r && ready_go;
    assign up.allowin = !valid_r || (ready_go && out_allowin);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
        end else if (up.allowin) begin
            valid_r <= up.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (up.valid && up.allowin) begin
            pc_r         <= up.pc;
            dest_r       <= up.dest;
            ls_type_r    <= up.ls_type;
            load_r       <= up.load;
            store_r      <= up.store;
            addr_r       <= up.addr;
            rs_value_r   <= up.rs_value;
            rt_value_r   <= up.rt_value;
            alu_result_r <= up.alu_result;
            hilo_cmd_r   <= up.hilo_cmd;
            mul_res_r    <= up.mul_res;
        end
    end

    // request taken, keep it from going out again
    always_ff @(posedge clk) begin
        if (reset) begin
            accepted <= 1'b0;
        end else if (leave) begin
            accepted <= 1'b0;
        end else if (dcache_valid && dcache_addr_ok) begin
            accepted <= 1'b1;
        end
    end

    assign vaddr = ls_type_r[LS_WL] ? {addr_r[31:2], 2'b00} : addr_r;
    assign paddr = {3'b000, vaddr[28:0]};   // fixed map, top bits dropped

    assign dcache_valid   = valid_r && mem_op && !accepted;
    assign dcache_op      = store_r;
    assign dcache_uncache = (vaddr[31:29] == UNCACHED_SEGMENT);
    assign dcache_tag     = paddr[31 -: TAG_W];
    assign dcache_index   = paddr[CACHE_OFFSET_W +: CACHE_INDEX_W];
    assign dcache_offset  = paddr[CACHE_OFFSET_W-1:0];

    store_format u_store_format (
        .ls_type  (ls_type_r),
        .offset   (addr_r[1:0]),
        .store    (store_r),
        .rt_value (rt_value_r),
        .wstrb    (dcache_wstrb),
        .size     (dcache_size),
        .wdata    (dcache_wdata)
    );

    hilo_regs u_hilo_regs (
        .clk      (clk),
        .reset    (reset),
        .cmd      (hilo_cmd_r),
        .commit   (leave),
        .rs_value (rs_value_r),
        .mul_res  (mul_res_r),
        .rd_value (hilo_value)
    );

    assign out_pc      = pc_r;
    assign out_dest    = dest_r;
    assign out_load    = load_r;
    assign out_ls_type = ls_type_r;
    assign out_offset  = addr_r[1:0];
    assign out_result  = (hilo_cmd_r == HILO_MFHI || hilo_cmd_r == HILO_MFLO) ? hilo_value
                                                                           : alu_result_r;

endmodule

// File: logic/hilo_regs.sv
module hilo_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  cpu_types_pkg::hilo_cmd_t cmd,
    input  logic                   commit,
    input  cpu_types_pkg::word_t     rs_value,
    input  cpu_types_pkg::dword_t    mul_res,
    output cpu_types_pkg::word_t     rd_value
);
    import cpu_types_pkg::*;

    word_t hi;
    word_t lo;

    // updated only when the owning instruction leaves the stage
    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (commit) begin
            case (cmd)
                HILO_MTHI: hi <= rs_value;
                HILO_MTLO: lo <= rs_value;
                HILO_MULT: begin
                    hi <= mul_res[63:32];
                    lo <= mul_res[31:0];
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (cmd)
            HILO_MFHI: rd_value = hi;
            HILO_MFLO: rd_value = lo;
            default:   rd_value = '0;
        endcase
    end

endmodule

// File: logic/mem_op_pkg.sv
package mem_op_pkg;

    typedef logic [6:0] ls_type_t;  // one-hot
    typedef logic [3:0] wstrb_t;
    typedef logic [1:0] acc_size_t;
    typedef logic [1:0] byte_off_t;

    // bit positions inside ls_type_t
    localparam int LS_B  = 6;
    localparam int LS_BU = 5;
    localparam int LS_H  = 4;
    localparam int LS_HU = 3;
    localparam int LS_W  = 2;
    localparam int LS_WL = 1; // word left, unaligned high part
    localparam int LS_WR = 0; // word right, unaligned low part

    localparam acc_size_t SIZE_BYTE = 2'd0;
    localparam acc_size_t SIZE_HALF = 2'd1;
    localparam acc_size_t SIZE_WORD = 2'd2;

    // kseg1, bypasses the cache
    localparam logic [2:0] UNCACHED_SEGMENT = 3'b101;

endpackage

// File: logic/premem_entry_stage.sv
module premem_entry_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    output logic                   in_allowin,
    input  cpu_types_pkg::word_t     in_pc,
    input  cpu_types_pkg::reg_idx_t  in_dest,
    input  mem_op_pkg::ls_type_t     in_ls_type,
    input  logic                   in_load,
    input  logic                   in_store,
    input  cpu_types_pkg::word_t     in_addr,
    input  cpu_types_pkg::word_t     in_rs_value,
    input  cpu_types_pkg::word_t     in_rt_value,
    input  cpu_types_pkg::word_t     in_alu_result,
    input  cpu_types_pkg::hilo_cmd_t in_hilo_cmd,
    input  cpu_types_pkg::dword_t    in_mul_res,
    output logic                   ex_valid,
    output cpu_types_pkg::exccode_t  ex_code,
    output cpu_types_pkg::word_t     ex_badvaddr,
    output cpu_types_pkg::word_t     ex_pc,
    stage_if.entry                 down
);
    import cpu_types_pkg::*;
    import mem_op_pkg::*;

    logic      valid_r;
    word_t     pc_r;
    reg_idx_t  dest_r;
    ls_type_t  ls_type_r;
    logic      load_r;
    logic      store_r;
    word_t     addr_r;
    word_t     rs_value_r;
    word_t     rt_value_r;
    word_t     alu_result_r;
    hilo_cmd_t hilo_cmd_r;
    dword_t    mul_res_r;
    logic      bad_align;
    logic      misaligned;

    // an excepting item is dropped, so it always leaves
    assign in_allowin = !valid_r || misaligned || down.allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
        end else if (in_allowin) begin
            valid_r <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            pc_r         <= in_pc;
            dest_r       <= in_dest;
            ls_type_r    <= in_ls_type;
            load_r       <= in_load;
            store_r      <= in_store;
            addr_r       <= in_addr;
            rs_value_r   <= in_rs_value;
            rt_value_r   <= in_rt_value;
            alu_result_r <= in_alu_result;
            hilo_cmd_r   <= in_hilo_cmd;
            mul_res_r    <= in_mul_res;
        end
    end

    assign bad_align = ((ls_type_r[LS_H] || ls_type_r[LS_HU]) && addr_r[0])
                    || (ls_type_r[LS_W] && (addr_r[1:0] != 2'b00));
    assign misaligned = valid_r && (load_r || store_r) && bad_align;

    assign ex_valid    = misaligned;
    assign ex_code     = store_r ? EXC_ADES : EXC_ADEL;
    assign ex_badvaddr = addr_r;
    assign ex_pc       = pc_r;

    assign down.valid      = valid_r && !misaligned;
    assign down.pc         = pc_r;
    assign down.dest       = dest_r;
    assign down.ls_type    = ls_type_r;
    assign down.load       = load_r;
    assign down.store      = store_r;
    assign down.addr       = addr_r;
    assign down.rs_value   = rs_value_r;
    assign down.rt_value   = rt_value_r;
    assign down.alu_result = alu_result_r;
    assign down.hilo_cmd   = hilo_cmd_r;
    assign down.mul_res    = mul_res_r;

endmodule

// File: logic/premem_pipe.sv
module premem_pipe #(
    parameter int CACHE_INDEX_W  = 8,
    parameter int CACHE_OFFSET_W = 4
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     in_valid,
    output logic                                     in_allowin,
    input  cpu_types_pkg::word_t                     in_pc,
    input  cpu_types_pkg::reg_idx_t                  in_dest,
    input  mem_op_pkg::ls_type_t                     in_ls_type,
    input  logic                                     in_load,
    input  logic                                     in_store,
    input  cpu_types_pkg::word_t                     in_addr,
    input  cpu_types_pkg::word_t                     in_rs_value,
    input  cpu_types_pkg::word_t                     in_rt_value,
    input  cpu_types_pkg::word_t                     in_alu_result,
    input  cpu_types_pkg::hilo_cmd_t                 in_hilo_cmd,
    input  cpu_types_pkg::dword_t                    in_mul_res,
    output logic                                     ex_valid,
    output cpu_types_pkg::exccode_t                  ex_code,
    output cpu_types_pkg::word_t                     ex_badvaddr,
    output cpu_types_pkg::word_t                     ex_pc,
    output logic                                     dcache_valid,
    output logic                                     dcache_op,
    output logic                                     dcache_uncache,
    output logic [31-CACHE_INDEX_W-CACHE_OFFSET_W:0] dcache_tag,
    output logic [CACHE_INDEX_W-1:0]                 dcache_index,
    output logic [CACHE_OFFSET_W-1:0]                dcache_offset,
    output mem_op_pkg::acc_size_t                    dcache_size,
    output mem_op_pkg::wstrb_t                       dcache_wstrb,
    output cpu_types_pkg::word_t                     dcache_wdata,
    input  logic                                     dcache_addr_ok,
    output logic                                     out_valid,
    input  logic                                     out_allowin,
    output cpu_types_pkg::word_t                     out_pc,
    output cpu_types_pkg::reg_idx_t                  out_dest,
    output logic                                     out_load,
    output mem_op_pkg::ls_type_t                     out_ls_type,
    output mem_op_pkg::byte_off_t                    out_offset,
    output cpu_types_pkg::word_t                     out_result
);

    stage_if stage_bus ();

    premem_entry_stage u_entry (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_allowin(in_allowin),
        .in_pc(in_pc), .in_dest(in_dest), .in_ls_type(in_ls_type),
        .in_load(in_load), .in_store(in_store), .in_addr(in_addr),
        .in_rs_value(in_rs_value), .in_rt_value(in_rt_value),
        .in_alu_result(in_alu_result), .in_hilo_cmd(in_hilo_cmd),
        .in_mul_res(in_mul_res),
        .ex_valid(ex_valid), .ex_code(ex_code),
        .ex_badvaddr(ex_badvaddr), .ex_pc(ex_pc),
        .down(stage_bus.entry)
    );

    dcache_request_stage #(
        .CACHE_INDEX_W  (CACHE_INDEX_W),
        .CACHE_OFFSET_W (CACHE_OFFSET_W)
    ) u_request (
        .clk(clk), .reset(reset),
        .up(stage_bus.request),
        .dcache_valid(dcache_valid), .dcache_op(dcache_op),
        .dcache_uncache(dcache_uncache), .dcache_tag(dcache_tag),
        .dcache_index(dcache_index), .dcache_offset(dcache_offset),
        .dcache_size(dcache_size), .dcache_wstrb(dcache_wstrb),
        .dcache_wdata(dcache_wdata), .dcache_addr_ok(dcache_addr_ok),
        .out_valid(out_valid), .out_allowin(out_allowin),
        .out_pc(out_pc), .out_dest(out_dest), .out_load(out_load),
        .out_ls_type(out_ls_type), .out_offset(out_offset),
        .out_result(out_result)
    );

endmodule

// File: logic/stage_if.sv
interface stage_if;
    import cpu_types_pkg::*;
    import mem_op_pkg::*;

    logic      valid;
    logic      allowin;

    word_t     pc;
    reg_idx_t  dest;
    ls_type_t  ls_type;
    logic      load;
    logic      store;
    word_t     addr;
    word_t     rs_value;
    word_t     rt_value;
    word_t     alu_result;
    hilo_cmd_t hilo_cmd;
    dword_t    mul_res;

    modport entry (
        output valid, pc, dest, ls_type, load, store, addr,
        output rs_value, rt_value, alu_result, hilo_cmd, mul_res,
        input  allowin
    );

    modport request (
        input  valid, pc, dest, ls_type, load, store, addr,
        input  rs_value, rt_value, alu_result, hilo_cmd, mul_res,
        output allowin
    );

endinterface

// File: logic/store_format.sv
module store_format (
    input  mem_op_pkg::ls_type_t  ls_type,
    input  mem_op_pkg::byte_off_t offset,
    input  logic                store,
    input  cpu_types_pkg::word_t  rt_value,
    output mem_op_pkg::wstrb_t    wstrb,
    output mem_op_pkg::acc_size_t size,
    output cpu_types_pkg::word_t  wdata
);
    import mem_op_pkg::*;

    wstrb_t strb;

    always_comb begin
        strb  = 4'b0000;
        size  = SIZE_WORD;
        wdata = rt_value;
        if (ls_type[LS_B] || ls_type[LS_BU]) begin
            strb  = 4'b0001 << offset;
            size  = SIZE_BYTE;
            wdata = {4{rt_value[7:0]}};
        end else if (ls_type[LS_H] || ls_type[LS_HU]) begin
            strb  = offset[1] ? 4'b1100 : 4'b0011;
            size  = SIZE_HALF;
            wdata = {2{rt_value[15:0]}};
        end else if (ls_type[LS_W]) begin
            strb  = 4'b1111;
            size  = SIZE_WORD;
            wdata = rt_value;
        end else if (ls_type[LS_WL]) begin
            strb  = 4'b1111 >> (~offset);   // 3 - offset
            wdata = rt_value >> {~offset, 3'b000};
            case (offset)
                2'd0:    size = SIZE_BYTE;
                2'd1:    size = SIZE_HALF;
                default: size = SIZE_WORD;
            endcase
        end else if (ls_type[LS_WR]) begin
            strb  = 4'b1111 << offset;
            wdata = rt_value << {offset, 3'b000};
            case (offset)
                2'd2:    size = SIZE_HALF;
                2'd3:    size = SIZE_BYTE;
                default: size = SIZE_WORD;
            endcase
        end
    end

    assign wstrb = store ? strb : 4'b0000; // loads write nothing

endmodule

// File: premem_pipe.f
logic/cpu_types_pkg.sv
logic/mem_op_pkg.sv
logic/stage_if.sv
logic/store_format.sv
logic/hilo_regs.sv
logic/premem_entry_stage.sv
logic/dcache_request_stage.sv
logic/premem_pipe.sv
tests/premem_pipe_tb.sv

// File: tests/premem_pipe_tb.sv
module premem_pipe_tb;
    import cpu_types_pkg::*;
    import mem_op_pkg::*;

    localparam int INDEX_W     = 8;
    localparam int OFFSET_W    = 4;
    localparam int TAG_W       = 32 - INDEX_W - OFFSET_W;
    localparam int DRIVE_DELAY = 2;
    localparam int TIMEOUT     = 200;

    typedef struct packed {
        word_t     pc;
        reg_idx_t  dest;
        logic      load;
        ls_type_t  ls_type;
        byte_off_t offset;
        word_t     result;
    } out_item_t;

    typedef struct packed {
        logic               op;
        logic               uncache;
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic [OFFSET_W-1:0] offset;
        acc_size_t          size;
        wstrb_t             wstrb;
        word_t              wdata;
    } req_item_t;

    typedef struct packed {
        exccode_t code;
        word_t    badvaddr;
        word_t    pc;
    } exc_item_t;

    logic clk;
    logic reset;
    logic in_valid;
    logic in_allowin;
    word_t in_pc;
    reg_idx_t in_dest;
    ls_type_t in_ls_type;
    logic in_load;
    logic in_store;
    word_t in_addr;
    word_t in_rs_value;
    word_t in_rt_value;
    word_t in_alu_result;
    hilo_cmd_t in_hilo_cmd;
    dword_t in_mul_res;
    logic ex_valid;
    exccode_t ex_code;
    word_t ex_badvaddr;
    word_t ex_pc;
    logic dcache_valid;
    logic dcache_op;
    logic dcache_uncache;
    logic [TAG_W-1:0] dcache_tag;
    logic [INDEX_W-1:0] dcache_index;
    logic [OFFSET_W-1:0] dcache_offset;
    acc_size_t dcache_size;
    wstrb_t dcache_wstrb;
    word_t dcache_wdata;
    logic dcache_addr_ok;
    logic out_valid;
    logic out_allowin;
    word_t out_pc;
    reg_idx_t out_dest;
    logic out_load;
    ls_type_t out_ls_type;
    byte_off_t out_offset;
    word_t out_result;

    integer seed = 13;
    string test_name = "reset";
    bit stalls_on;
    word_t next_pc;
    word_t model_hi;
    word_t model_lo;
    out_item_t out_q[$];
    req_item_t req_q[$];
    exc_item_t exc_q[$];

    out_item_t out_now;
    req_item_t req_now;
    exc_item_t exc_now;
    out_item_t prev_out;
    req_item_t prev_req;
    logic prev_out_valid;
    logic prev_out_allowin;
    logic prev_req_valid;
    logic prev_addr_ok;
    logic req_done;        // current item already had its addr_ok

    int allow_roll;
    int ack_roll;

    int i;
    int k;
    int off;
    int pick;
    word_t base;
    hilo_cmd_t cmd_pick;
    hilo_cmd_t hilo_seq[9];

    assign out_now = {out_pc, out_dest, out_load, out_ls_type, out_offset, out_result};
    assign req_now = {dcache_op, dcache_uncache, dcache_tag, dcache_index, dcache_offset,
                      dcache_size, dcache_wstrb, dcache_wdata};
    assign exc_now = {ex_code, ex_badvaddr, ex_pc};

    premem_pipe #(
        .CACHE_INDEX_W  (INDEX_W),
        .CACHE_OFFSET_W (OFFSET_W)
    ) dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Errors found");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_value(input string field, input logic [95:0] exp,
                               input logic [95:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, field, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic require(input bit cond, input string what);
        assert (cond) else begin
            $display("%s: %s", test_name, what);
            stop_with_failure();
        end
    endtask

    function automatic bit misaligned(input int kind, input word_t addr);
        if (kind == LS_H || kind == LS_HU)
            return addr[0];
        return (kind == LS_W) && (addr[1:0] != 2'b00);
    endfunction

    // expected request for one access
    function automatic req_item_t expect_request(input int kind, input logic st,
                                                 input word_t addr, input word_t rt);
        req_item_t r;
        word_t eff;
        word_t phys;
        int ofs;
        ofs = addr[1:0];
        eff = (kind == LS_WL) ? (addr & 32'hffff_fffc) : addr;
        phys = eff & 32'h1fff_ffff;
        r.op = st;
        r.uncache = (eff[31:29] == 3'b101);
        r.tag = phys[31:INDEX_W+OFFSET_W];
        r.index = phys[INDEX_W+OFFSET_W-1:OFFSET_W];
        r.offset = phys[OFFSET_W-1:0];
        case (kind)
            LS_B, LS_BU: begin
                r.size = SIZE_BYTE;
                r.wstrb = 4'b0001 << ofs;
                r.wdata = {4{rt[7:0]}};
            end
            LS_H, LS_HU: begin
                r.size = SIZE_HALF;
                r.wstrb = (ofs >= 2) ? 4'b1100 : 4'b0011;
                r.wdata = {2{rt[15:0]}};
            end
            LS_WL: begin
                r.size = (ofs == 0) ? SIZE_BYTE : (ofs == 1) ? SIZE_HALF : SIZE_WORD;
                r.wstrb = (ofs == 0) ? 4'b0001 : (ofs == 1) ? 4'b0011
                        : (ofs == 2) ? 4'b0111 : 4'b1111;
                r.wdata = rt >> (8 * (3 - ofs));
            end
            LS_WR: begin
                r.size = (ofs == 3) ? SIZE_BYTE : (ofs == 2) ? SIZE_HALF : SIZE_WORD;
                r.wstrb = (ofs == 0) ? 4'b1111 : (ofs == 1) ? 4'b1110
                        : (ofs == 2) ? 4'b1100 : 4'b1000;
                r.wdata = rt << (8 * ofs);
            end
            default: begin
                r.size = SIZE_WORD;
                r.wstrb = 4'b1111;
                r.wdata = rt;
            end
        endcase
        if (!st)
            r.wstrb = 4'b0000;      // loads never write
        return r;
    endfunction

    // kind is an ls_type bit position or -1 for a non-memory item
    task automatic send_item(input int kind, input logic ld, input logic st,
                             input word_t addr, input hilo_cmd_t cmd);
        out_item_t o;
        exc_item_t e;
        int n;
        bit taken;
        in_pc = next_pc;
        next_pc = next_pc + 4;
        in_dest = $random(seed);
        in_rs_value = $random(seed);
        in_rt_value = $random(seed);
        in_alu_result = $random(seed);
        in_mul_res = {$random(seed), $random(seed)};
        in_ls_type = '0;
        if (kind >= 0)
            in_ls_type[kind] = 1'b1;
        in_load = ld;
        in_store = st;
        in_addr = addr;
        in_hilo_cmd = cmd;
        in_valid = 1'b1;
        if ((ld || st) && misaligned(kind, addr)) begin
            e.code = st ? EXC_ADES : EXC_ADEL;
            e.badvaddr = addr;
            e.pc = in_pc;
            exc_q.push_back(e);
        end else begin
            o.pc = in_pc;
            o.dest = in_dest;
            o.load = ld;
            o.ls_type = in_ls_type;
            o.offset = addr[1:0];
            o.result = in_alu_result;
            case (cmd)                  // in-order hi/lo model
                HILO_MFHI: o.result = model_hi;
                HILO_MFLO: o.result = model_lo;
                HILO_MTHI: model_hi = in_rs_value;
                HILO_MTLO: model_lo = in_rs_value;
                HILO_MULT: {model_hi, model_lo} = in_mul_res;
                default: ;
            endcase
            out_q.push_back(o);
            if (ld || st)
                req_q.push_back(expect_request(kind, st, addr, in_rt_value));
        end
        n = 0;
        taken = 1'b0;
        while (!taken && n < TIMEOUT) begin
            @(posedge clk);
            taken = in_allowin;
            #DRIVE_DELAY;
            n++;
        end
        require(taken, "input transfer timed out, in_allowin stayed low");
    endtask

    task automatic drain();
        int n;
        n = 0;
        in_valid = 1'b0;
        while ((out_q.size() + req_q.size() + exc_q.size()) != 0 && n < TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            n++;
        end
        require((out_q.size() + req_q.size() + exc_q.size()) == 0,
                "timed out waiting for expected results to come out");
    endtask

    // random back-pressure and addr_ok delay
    always @(posedge clk) begin
        allow_roll = $random(seed);
        ack_roll = $random(seed);
        #DRIVE_DELAY;
        if (stalls_on) begin
            out_allowin = (allow_roll % 3) != 0;
            dcache_addr_ok = (ack_roll % 3) == 0;
        end else begin
            out_allowin = 1'b1;
            dcache_addr_ok = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            prev_out_valid = 1'b0;
            prev_req_valid = 1'b0;
            req_done = 1'b0;
        end else begin
            if (prev_out_valid && !prev_out_allowin) begin
                require(out_valid, "out_valid dropped while out_allowin was low");
                check_value("held output", prev_out, out_now);
            end
            if (prev_req_valid && !prev_addr_ok) begin
                require(dcache_valid, "dcache_valid dropped before addr_ok");
                check_value("held request", prev_req, req_now);
            end
            require(!(req_done && dcache_valid), "cache request repeated after addr_ok");
            if (ex_valid) begin
                require(exc_q.size() != 0, "exception reported with none expected");
                if (exc_q.size() != 0)
                    check_value("exception", exc_q.pop_front(), exc_now);
            end
            if (dcache_valid && dcache_addr_ok) begin
                require(req_q.size() != 0, "cache request issued with none expected");
                if (req_q.size() != 0)
                    check_value("cache request", req_q.pop_front(), req_now);
            end
            if (out_valid && out_allowin) begin
                require(out_q.size() != 0, "output item with none expected");
                if (out_q.size() != 0)
                    check_value("output", out_q.pop_front(), out_now);
            end
            if (out_valid && out_allowin)
                req_done = 1'b0;
            else if (dcache_valid && dcache_addr_ok)
                req_done = 1'b1;
            prev_out_valid = out_valid;
            prev_out_allowin = out_allowin;
            prev_out = out_now;
            prev_req_valid = dcache_valid;
            prev_addr_ok = dcache_addr_ok;
            prev_req = req_now;
        end
    end

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_pc = '0;
        in_dest = '0;
        in_ls_type = '0;
        in_load = 1'b0;
        in_store = 1'b0;
        in_addr = '0;
        in_rs_value = '0;
        in_rt_value = '0;
        in_alu_result = '0;
        in_hilo_cmd = HILO_NONE;
        in_mul_res = '0;
        out_allowin = 1'b1;
        dcache_addr_ok = 1'b0;
        stalls_on = 1'b0;
        next_pc = 32'hbfc0_0000;
        model_hi = '0;
        model_lo = '0;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        require(!out_valid && !ex_valid && !dcache_valid, "outputs not idle after reset");

        test_name = "alu_pass";
        for (i = 0; i < 8; i++)
            send_item(-1, 1'b0, 1'b0, 32'h0, HILO_NONE);
        drain();

        test_name = "store_format";
        for (k = 0; k < 7; k++) begin
            for (off = 0; off < 4; off++) begin
                base = $random(seed);
                if (off % 2)
                    base[31:29] = UNCACHED_SEGMENT;
                base[1:0] = off;
                if (!misaligned(k, base)) begin
                    send_item(k, 1'b0, 1'b1, base, HILO_NONE);
                    send_item(k, 1'b1, 1'b0, base, HILO_NONE);
                end
            end
        end
        drain();

        test_name = "misaligned";
        stalls_on = 1'b1;
        send_item(LS_H, 1'b1, 1'b0, 32'h8000_1001, HILO_NONE);
        send_item(LS_HU, 1'b1, 1'b0, 32'h8000_2003, HILO_NONE);
        send_item(-1, 1'b0, 1'b0, 32'h0, HILO_NONE);
        send_item(LS_W, 1'b1, 1'b0, 32'h8000_3002, HILO_NONE);
        send_item(LS_H, 1'b0, 1'b1, 32'ha000_0101, HILO_NONE);
        send_item(LS_W, 1'b0, 1'b1, 32'h8000_4001, HILO_NONE);
        send_item(LS_W, 1'b0, 1'b1, 32'h8000_4003, HILO_NONE);
        send_item(LS_W, 1'b1, 1'b0, 32'h8000_5000, HILO_NONE);
        drain();

        test_name = "hilo";
        hilo_seq = '{HILO_MFHI, HILO_MFLO, HILO_MTHI, HILO_MTLO, HILO_MFHI,
                     HILO_MFLO, HILO_MULT, HILO_MFHI, HILO_MFLO};
        foreach (hilo_seq[j])
            send_item(-1, 1'b0, 1'b0, 32'h0, hilo_seq[j]);
        drain();

        test_name = "backpressure";
        for (i = 0; i < 60; i++) begin
            pick = {$random(seed)} % 4;
            k = {$random(seed)} % 7;
            base = $random(seed);
            cmd_pick = {$random(seed)} % 6;
            case (pick)
                0: send_item(-1, 1'b0, 1'b0, 32'h0, cmd_pick);
                1: send_item(k, 1'b1, 1'b0, base, HILO_NONE);
                2: send_item(k, 1'b0, 1'b1, base, HILO_NONE);
                default: begin
                    in_valid = 1'b0;    // one idle cycle on the input
                    @(posedge clk);
                    #DRIVE_DELAY;
                    send_item(-1, 1'b0, 1'b0, 32'h0, HILO_NONE);
                end
            endcase
        end
        drain();

        if (!out_valid && !dcache_valid && !ex_valid) begin
            $display("No errors");
            $finish;
        end else begin
            $display("pipeline still busy after all results came out");
            stop_with_failure();
        end
    end

endmodule
